// File: hdl/pic_pkg.sv
package pic_pkg;

	typedef logic [31:0] word_t;	// Data or address word
	typedef logic [5:0] irq_num_t;	// Interrupt number
	typedef logic [1:0] order_t;	// Access order

	localparam order_t ORDER_WORD = 2'h2;	// Only legal write order

	// Address map
	localparam word_t GCI_BASE = 32'h0000_0200;	// First GCI address
	localparam word_t GCI_SIZE_REG = 32'h0000_0004;
	localparam word_t GCI_SCRATCH_OFS = 32'h0000_0000;
	localparam word_t GCI_DOORBELL_OFS = 32'h0000_0010;
	localparam word_t GCI_SIZE_BYTES = 32'h0000_1000;	// Size the GCI reports

	localparam word_t DPS_SCRATCH0_OFS = 32'h0000_0000;
	localparam word_t DPS_SCRATCH1_OFS = 32'h0000_0004;
	localparam word_t DPS_TIMER_OFS = 32'h0000_0008;	// Write starts countdown
	localparam word_t DPS_STATUS_OFS = 32'h0000_000C;	// Timer running, read only

	// Interrupt numbers
	localparam irq_num_t GCI_IRQ_OFFSET = 6'd4;
	localparam irq_num_t DPS_TIMER_IRQ = 6'd1;
	localparam irq_num_t GCI_DOORBELL_IRQ = 6'd2;

	typedef struct packed {
		logic rw;	// 1 = read
		order_t order;
		word_t addr;
		word_t data;
	} io_req_t;

	typedef struct packed {
		logic rw;	// 1 = write
		word_t addr;
		word_t data;
	} dev_req_t;

	typedef struct packed {
		logic req;	// Level, held until ack
		irq_num_t num;
	} irq_req_t;

	typedef enum logic {IRQ_IDLE, IRQ_ACK_WAIT} irq_state_t;

	typedef enum logic [1:0] {PROBE_IDLE, PROBE_REQUEST, PROBE_WAIT, PROBE_DONE} probe_state_t;

endpackage

// File: hdl/pic_request_buffer.sv
`timescale 1ns/1ps

module pic_request_buffer import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic io_req,	// Already qualified by the controller
	input io_req_t io_cmd,
	input logic accept,	// Both devices free
	output logic cpu_req,
	output io_req_t cpu_cmd
);

	logic fault;	// Alignment fault flag
	logic misaligned;

	// Write of any order but word
	assign misaligned = io_req && !io_cmd.rw && (io_cmd.order != ORDER_WORD);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			fault <= 1'b0;
			cpu_req <= 1'b0;
		end else if (accept) begin
			if (misaligned) begin
				fault <= 1'b1;	// Dropped before any device
				cpu_req <= 1'b0;
			end else begin
				fault <= 1'b0;
				cpu_req <= io_req;
			end
		end
	end

	// Command payload
	always_ff @(posedge iCLOCK) begin
		if (accept && io_req && !misaligned) begin
			cpu_cmd <= io_cmd;
		end
	end

	// Nothing misaligned leaves the buffer
	a_no_misaligned_write: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		cpu_req |-> (cpu_cmd.rw || cpu_cmd.order == ORDER_WORD)
	);

endmodule

// File: hdl/pic_irq_control.sv
`timescale 1ns/1ps

module pic_irq_control import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input irq_req_t gci_irq,
	input irq_req_t dps_irq,
	input logic irq_ack,	// Strobe from CPU
	output logic irq_valid,
	output irq_num_t irq_num,
	output logic gci_irq_ack,
	output logic dps_irq_ack
);

	irq_state_t state;
	logic gci_mask;	// Source recorded on entry to ACK_WAIT
	logic dps_mask;

	// Ack goes only to the source that was granted
	assign gci_irq_ack = gci_mask && irq_ack;
	assign dps_irq_ack = dps_mask && irq_ack;

	assign irq_valid = (state == IRQ_IDLE) && (gci_irq.req || dps_irq.req);
	// GCI first, numbers shifted up
	assign irq_num = gci_irq.req ? gci_irq.num + GCI_IRQ_OFFSET : dps_irq.num;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IRQ_IDLE;
			gci_mask <= 1'b0;
			dps_mask <= 1'b0;
		end else begin
			case (state)
				IRQ_IDLE: begin
					gci_mask <= 1'b0;
					dps_mask <= 1'b0;
					if (gci_irq.req) begin
						state <= IRQ_ACK_WAIT;
						gci_mask <= 1'b1;
					end else if (dps_irq.req) begin
						state <= IRQ_ACK_WAIT;
						dps_mask <= 1'b1;
					end
				end
				IRQ_ACK_WAIT: begin
					if (irq_ack) state <= IRQ_IDLE;	// Source drops its level on this edge
				end
				default: state <= IRQ_IDLE;
			endcase
		end
	end

	a_one_ack: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(gci_irq_ack && dps_irq_ack)
	);

endmodule

// File: hdl/pic_gci_size_probe.sv
`timescale 1ns/1ps

module pic_gci_size_probe import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic gci_busy,
	input logic gci_ret,
	input word_t gci_ret_data,
	output logic probe_req,	// Controller swaps in the size read
	output logic probe_done,
	output word_t iosr
);

	probe_state_t state;
	word_t gci_size;

	assign probe_req = (state == PROBE_REQUEST);
	assign probe_done = (state == PROBE_DONE);
	// IO space starts below zero by size plus base
	assign iosr = -(gci_size + GCI_BASE);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= PROBE_IDLE;
			gci_size <= '0;
		end else begin
			case (state)
				PROBE_IDLE: begin
					if (!gci_busy) state <= PROBE_REQUEST;
				end
				PROBE_REQUEST: begin
					if (!gci_busy) state <= PROBE_WAIT;	// GCI takes the read here
				end
				PROBE_WAIT: begin
					if (gci_ret) begin
						state <= PROBE_DONE;
						gci_size <= gci_ret_data;
					end
				end
				PROBE_DONE: begin
					// Stays until reset
				end
				default: state <= PROBE_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/peripheral_interface_controller.sv
`timescale 1ns/1ps

module peripheral_interface_controller import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	// CPU side
	input logic io_req,
	input io_req_t io_cmd,
	output logic io_busy,
	output logic io_valid,
	output word_t io_data,
	input logic io_ret_busy,
	output logic io_irq_valid,
	output irq_num_t io_irq_num,
	input logic io_irq_ack,
	output logic sysinfo_iosr_valid,
	output word_t sysinfo_iosr,
	// DPS
	output logic dps_req,
	output dev_req_t dps_cmd,
	input logic dps_busy,
	input logic dps_ret,
	input word_t dps_ret_data,
	output logic dps_ret_busy,
	input irq_req_t dps_irq,
	output logic dps_irq_ack,
	// GCI
	output logic gci_req,
	output dev_req_t gci_cmd,
	input logic gci_busy,
	input logic gci_ret,
	input word_t gci_ret_data,
	output logic gci_ret_busy,
	input irq_req_t gci_irq,
	output logic gci_irq_ack
);

	logic accept;	// Both devices can take a request
	logic cpu_req;
	io_req_t cpu_cmd;
	logic sel_gci;
	logic probe_req;
	logic probe_done;

	assign accept = !dps_busy && !gci_busy;
	assign io_busy = !accept || !probe_done;
	assign sel_gci = (cpu_cmd.addr >= GCI_BASE);

	pic_request_buffer u_req_buf (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.io_req(io_req && probe_done),	// Nothing before IOSR is known
		.io_cmd(io_cmd), .accept(accept),
		.cpu_req(cpu_req), .cpu_cmd(cpu_cmd)
	);

	pic_irq_control u_irq_ctrl (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.gci_irq(gci_irq), .dps_irq(dps_irq), .irq_ack(io_irq_ack),
		.irq_valid(io_irq_valid), .irq_num(io_irq_num),
		.gci_irq_ack(gci_irq_ack), .dps_irq_ack(dps_irq_ack)
	);

	pic_gci_size_probe u_probe (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.gci_busy(gci_busy), .gci_ret(gci_ret), .gci_ret_data(gci_ret_data),
		.probe_req(probe_req), .probe_done(probe_done), .iosr(sysinfo_iosr)
	);

	assign sysinfo_iosr_valid = probe_done;

	// Requests held off while the other device stalls
	assign dps_req = cpu_req && !sel_gci && accept;
	assign gci_req = probe_req || (cpu_req && sel_gci && accept);

	always_comb begin
		dps_cmd.rw = !cpu_cmd.rw;	// CPU 1 = read, device 1 = write
		dps_cmd.addr = cpu_cmd.addr;
		dps_cmd.data = cpu_cmd.data;
		if (probe_req) begin
			gci_cmd.rw = 1'b0;	// Size read
			gci_cmd.addr = GCI_SIZE_REG;
			gci_cmd.data = '0;
		end else begin
			gci_cmd.rw = !cpu_cmd.rw;
			gci_cmd.addr = cpu_cmd.addr - GCI_BASE;	// Device local offset
			gci_cmd.data = cpu_cmd.data;
		end
	end

	// Returns to CPU, probe return kept internal
	assign io_valid = probe_done && (gci_ret || dps_ret);
	assign io_data = gci_ret ? gci_ret_data : dps_ret_data;
	assign dps_ret_busy = io_ret_busy;
	assign gci_ret_busy = probe_done && io_ret_busy;

endmodule

// File: hdl/dps_register_block.sv
`timescale 1ns/1ps

module dps_register_block import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic req,
	input dev_req_t cmd,
	output logic busy,
	output logic ret,
	output word_t ret_data,
	input logic ret_busy,
	output irq_req_t irq,
	input logic irq_ack
);

	word_t scratch0;
	word_t scratch1;
	word_t count;	// Timer count
	logic running;
	logic irq_pend;
	logic take;
	word_t rd_word;

	assign busy = ret && ret_busy;	// Stalled return blocks new work
	assign take = req && !busy;

	assign irq.req = irq_pend;
	assign irq.num = DPS_TIMER_IRQ;

	// Read mux
	always_comb begin
		case (cmd.addr)
			DPS_SCRATCH0_OFS: rd_word = scratch0;
			DPS_SCRATCH1_OFS: rd_word = scratch1;
			DPS_TIMER_OFS: rd_word = count;
			DPS_STATUS_OFS: rd_word = {31'b0, running};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) ret <= 1'b0;
		else if (take) ret <= !cmd.rw;	// Reads only
		else if (!ret_busy) ret <= 1'b0;
	end

	// Data registers
	always_ff @(posedge iCLOCK) begin
		if (take && !cmd.rw) ret_data <= rd_word;
		if (take && cmd.rw && cmd.addr == DPS_SCRATCH0_OFS) scratch0 <= cmd.data;
		if (take && cmd.rw && cmd.addr == DPS_SCRATCH1_OFS) scratch1 <= cmd.data;
	end

	// Countdown timer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			running <= 1'b0;
			irq_pend <= 1'b0;
		end else begin
			if (irq_ack) irq_pend <= 1'b0;
			if (take && cmd.rw && cmd.addr == DPS_TIMER_OFS) begin
				count <= cmd.data;	// Restart
				running <= 1'b1;
			end else if (running) begin
				if (count == '0) begin
					running <= 1'b0;
					irq_pend <= 1'b1;	// Expired
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/gci_register_block.sv
`timescale 1ns/1ps

module gci_register_block import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic req,
	input dev_req_t cmd,
	output logic busy,
	output logic ret,
	output word_t ret_data,
	input logic ret_busy,
	output irq_req_t irq,
	input logic irq_ack
);

	word_t scratch;
	logic doorbell;	// Pending doorbell interrupt
	logic take;
	word_t rd_word;

	assign busy = ret && ret_busy;
	assign take = req && !busy;

	assign irq.req = doorbell;
	assign irq.num = GCI_DOORBELL_IRQ;

	always_comb begin
		case (cmd.addr)
			GCI_SCRATCH_OFS: rd_word = scratch;
			GCI_SIZE_REG: rd_word = GCI_SIZE_BYTES;	// Fixed size
			GCI_DOORBELL_OFS: rd_word = {31'b0, doorbell};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ret <= 1'b0;
			doorbell <= 1'b0;
		end else begin
			if (take) ret <= !cmd.rw;
			else if (!ret_busy) ret <= 1'b0;
			if (irq_ack) doorbell <= 1'b0;
			// Ring wins over a same-cycle ack
			if (take && cmd.rw && cmd.addr == GCI_DOORBELL_OFS) doorbell <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (take && !cmd.rw) ret_data <= rd_word;
		if (take && cmd.rw && cmd.addr == GCI_SCRATCH_OFS) scratch <= cmd.data;
	end

	// Held return keeps its data
	a_ret_stable: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		ret && ret_busy |=> ret && $stable(ret_data)
	);

endmodule

// File: hdl/io_subsystem_top.sv
`timescale 1ns/1ps

module io_subsystem_top import pic_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic io_req,
	input io_req_t io_cmd,
	output logic io_busy,
	output logic io_valid,
	output word_t io_data,
	input logic io_ret_busy,
	output logic io_irq_valid,
	output irq_num_t io_irq_num,
	input logic io_irq_ack,
	output logic sysinfo_iosr_valid,
	output word_t sysinfo_iosr
);

	logic dps_req, dps_busy, dps_ret, dps_ret_busy, dps_irq_ack;
	logic gci_req, gci_busy, gci_ret, gci_ret_busy, gci_irq_ack;
	dev_req_t dps_cmd, gci_cmd;
	word_t dps_ret_data, gci_ret_data;
	irq_req_t dps_irq, gci_irq;

	peripheral_interface_controller u_pic (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.io_req(io_req), .io_cmd(io_cmd), .io_busy(io_busy),
		.io_valid(io_valid), .io_data(io_data), .io_ret_busy(io_ret_busy),
		.io_irq_valid(io_irq_valid), .io_irq_num(io_irq_num), .io_irq_ack(io_irq_ack),
		.sysinfo_iosr_valid(sysinfo_iosr_valid), .sysinfo_iosr(sysinfo_iosr),
		.dps_req(dps_req), .dps_cmd(dps_cmd), .dps_busy(dps_busy),
		.dps_ret(dps_ret), .dps_ret_data(dps_ret_data), .dps_ret_busy(dps_ret_busy),
		.dps_irq(dps_irq), .dps_irq_ack(dps_irq_ack),
		.gci_req(gci_req), .gci_cmd(gci_cmd), .gci_busy(gci_busy),
		.gci_ret(gci_ret), .gci_ret_data(gci_ret_data), .gci_ret_busy(gci_ret_busy),
		.gci_irq(gci_irq), .gci_irq_ack(gci_irq_ack)
	);

	dps_register_block u_dps (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.req(dps_req), .cmd(dps_cmd), .busy(dps_busy),
		.ret(dps_ret), .ret_data(dps_ret_data), .ret_busy(dps_ret_busy),
		.irq(dps_irq), .irq_ack(dps_irq_ack)
	);

	gci_register_block u_gci (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.req(gci_req), .cmd(gci_cmd), .busy(gci_busy),
		.ret(gci_ret), .ret_data(gci_ret_data), .ret_busy(gci_ret_busy),
		.irq(gci_irq), .irq_ack(gci_irq_ack)
	);

endmodule

// File: tb/tb_io_subsystem.sv
`timescale 1ns/1ps

module tb_io_subsystem import pic_pkg::*; ();

	localparam int WAIT_LIMIT = 200;	// Cycles allowed per wait
	localparam int READ_LATENCY = 2;	// Acceptance to io_valid
	localparam order_t ORDER_BYTE = 2'h0;
	localparam order_t ORDER_HALF = 2'h1;

	logic iCLOCK;
	logic inRESET;
	logic io_req;
	io_req_t io_cmd;
	logic io_busy;
	logic io_valid;
	word_t io_data;
	logic io_ret_busy;
	logic io_irq_valid;
	irq_num_t io_irq_num;
	logic io_irq_ack;
	logic sysinfo_iosr_valid;
	word_t sysinfo_iosr;

	integer seed;
	int checks;
	int errors;
	int timeouts;

	io_subsystem_top u_io_subsystem_top (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.io_req(io_req), .io_cmd(io_cmd), .io_busy(io_busy),
		.io_valid(io_valid), .io_data(io_data), .io_ret_busy(io_ret_busy),
		.io_irq_valid(io_irq_valid), .io_irq_num(io_irq_num), .io_irq_ack(io_irq_ack),
		.sysinfo_iosr_valid(sysinfo_iosr_valid), .sysinfo_iosr(sysinfo_iosr)
	);

	always #20 iCLOCK = ~iCLOCK;	// 40 ns period

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_irq(input irq_num_t got, input irq_num_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s number is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Holds io_req until an edge sees io_busy low
	task automatic issue_request(input logic rw, input order_t order, input word_t addr,
			input word_t data, output logic taken);
		int n;
		n = 0;
		taken = 1'b0;
		io_req <= 1'b1;
		io_cmd.rw <= rw;	// 1 = read
		io_cmd.order <= order;
		io_cmd.addr <= addr;
		io_cmd.data <= data;
		while (!taken && n < WAIT_LIMIT) begin
			@(posedge iCLOCK);
			n++;
			if (!io_busy) taken = 1'b1;
		end
		io_req <= 1'b0;
		if (!taken) begin
			timeouts++;
			$display("Timeout: request to address %h was never accepted", addr);
		end
	endtask

	task automatic cpu_write(input word_t addr, input order_t order, input word_t data);
		logic taken;
		issue_request(1'b0, order, addr, data, taken);
	endtask

	// hold > 0 keeps io_ret_busy up for that many cycles after io_valid
	task automatic cpu_read(input word_t addr, input order_t order, input int hold,
			output word_t data);
		logic taken;
		int lat;
		int i;
		data = '0;
		lat = 0;
		if (hold > 0) io_ret_busy <= 1'b1;
		issue_request(1'b1, order, addr, '0, taken);
		if (taken) begin
			do begin
				@(posedge iCLOCK);
				lat++;
			end while (!io_valid && lat < WAIT_LIMIT);
			if (!io_valid) begin
				timeouts++;
				$display("Timeout: no read data came back from address %h", addr);
			end else begin
				check_word(word_t'(lat), word_t'(READ_LATENCY), "read latency");
				data = io_data;
				for (i = 0; i < hold; i++) begin
					@(posedge iCLOCK);
					check_flag(io_valid, 1'b1, "io_valid while stalled");
					check_flag(io_busy, 1'b1, "io_busy while stalled");
					check_word(io_data, data, "io_data while stalled");
				end
				if (hold > 0) begin
					io_ret_busy <= 1'b0;
					@(posedge iCLOCK);	// Completing edge
					check_flag(io_valid, 1'b1, "io_valid at release");
					check_word(io_data, data, "io_data at release");
					@(posedge iCLOCK);
					check_flag(io_valid, 1'b0, "io_valid after release");
				end
			end
		end
		io_ret_busy <= 1'b0;
	endtask

	task automatic wait_irq(input irq_num_t exp, input string what);
		int n;
		n = 0;
		do begin
			@(posedge iCLOCK);
			n++;
		end while (!io_irq_valid && n < WAIT_LIMIT);
		if (!io_irq_valid) begin
			timeouts++;
			$display("Timeout: no interrupt arrived for %s", what);
		end else begin
			check_irq(io_irq_num, exp, what);
		end
	endtask

	task automatic ack_irq();
		io_irq_ack <= 1'b1;	// One-cycle strobe
		@(posedge iCLOCK);
		io_irq_ack <= 1'b0;
	endtask

	task automatic irq_stays_low(input int cycles, input string what);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(posedge iCLOCK);
			check_flag(io_irq_valid, 1'b0, what);
		end
	endtask

	task automatic probe_startup();
		int n;
		n = 0;
		do begin
			@(posedge iCLOCK);
			n++;
			if (!sysinfo_iosr_valid) begin
				check_flag(io_busy, 1'b1, "io_busy during size probe");
				check_flag(io_valid, 1'b0, "io_valid during size probe");	// Probe data stays inside
			end
		end while (!sysinfo_iosr_valid && n < WAIT_LIMIT);
		if (!sysinfo_iosr_valid) begin
			timeouts++;
			$display("Timeout: sysinfo_iosr_valid never rose after reset");
		end else begin
			check_flag(io_busy, 1'b0, "io_busy with IOSR valid");
			// Negation of 0x1000 plus 0x200
			check_word(sysinfo_iosr, 32'hFFFF_EE00, "sysinfo_iosr");
		end
	endtask

	task automatic scratch_readback();
		word_t w0;
		word_t w1;
		word_t w2;
		word_t rd;
		w0 = $random(seed);
		w1 = $random(seed);
		w2 = $random(seed);
		cpu_write(DPS_SCRATCH0_OFS, ORDER_WORD, w0);
		cpu_write(DPS_SCRATCH1_OFS, ORDER_WORD, w1);
		cpu_write(32'h0000_0200, ORDER_WORD, w2);	// GCI scratch
		cpu_read(DPS_SCRATCH0_OFS, ORDER_WORD, 0, rd);
		check_word(rd, w0, "DPS scratch 0");
		cpu_read(DPS_SCRATCH1_OFS, ORDER_WORD, 0, rd);
		check_word(rd, w1, "DPS scratch 1");
		cpu_read(32'h0000_0200, ORDER_WORD, 0, rd);
		check_word(rd, w2, "GCI scratch");
		cpu_read(32'h0000_0204, ORDER_WORD, 0, rd);
		check_word(rd, GCI_SIZE_BYTES, "GCI size");
	endtask

	task automatic misaligned_drop();
		word_t good;
		word_t rd;
		good = $random(seed);
		cpu_write(DPS_SCRATCH1_OFS, ORDER_WORD, good);
		cpu_write(DPS_SCRATCH1_OFS, ORDER_HALF, ~good);	// Must be dropped
		cpu_write(32'h0000_0200, ORDER_WORD, ~good);
		cpu_write(32'h0000_0200, ORDER_BYTE, good);
		cpu_read(DPS_SCRATCH1_OFS, ORDER_BYTE, 0, rd);	// Odd order reads pass
		check_word(rd, good, "DPS scratch 1 after half write");
		cpu_read(32'h0000_0200, ORDER_HALF, 0, rd);
		check_word(rd, ~good, "GCI scratch after byte write");
		cpu_write(32'h0000_0210, ORDER_BYTE, good);	// Doorbell never rings
		irq_stays_low(10, "io_irq_valid after byte doorbell write");
	endtask

	task automatic single_irqs();
		word_t ring;
		ring = $random(seed);
		cpu_write(DPS_TIMER_OFS, ORDER_WORD, 32'd6);
		wait_irq(DPS_TIMER_IRQ, "DPS timer");
		ack_irq();
		irq_stays_low(10, "io_irq_valid after DPS ack");
		cpu_write(32'h0000_0210, ORDER_WORD, ring);
		wait_irq(GCI_DOORBELL_IRQ + 6'd4, "GCI doorbell");
		ack_irq();
		irq_stays_low(10, "io_irq_valid after GCI ack");
	endtask

	// Zero count expires on the same edge the doorbell lands
	task automatic irq_priority();
		cpu_write(DPS_TIMER_OFS, ORDER_WORD, 32'd0);
		cpu_write(32'h0000_0210, ORDER_WORD, 32'h1);
		wait_irq(GCI_DOORBELL_IRQ + 6'd4, "GCI doorbell, both pending");
		ack_irq();
		wait_irq(DPS_TIMER_IRQ, "DPS timer after GCI ack");
		ack_irq();
		irq_stays_low(10, "io_irq_valid after both acks");
	endtask

	task automatic stalled_return();
		word_t g;
		word_t d;
		word_t rd;
		g = $random(seed);
		d = $random(seed);
		cpu_write(32'h0000_0200, ORDER_WORD, g);
		cpu_write(DPS_SCRATCH0_OFS, ORDER_WORD, d);
		cpu_read(32'h0000_0200, ORDER_WORD, 4, rd);
		check_word(rd, g, "GCI scratch after stall");
		cpu_read(DPS_SCRATCH0_OFS, ORDER_WORD, 3, rd);
		check_word(rd, d, "DPS scratch 0 after stall");
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		io_req = 1'b0;
		io_cmd = '0;
		io_ret_busy = 1'b0;
		io_irq_ack = 1'b0;
		seed = 32'hec73_d3fc;
		checks = 0;
		errors = 0;
		timeouts = 0;
		repeat (5) @(posedge iCLOCK);
		check_flag(io_busy, 1'b1, "io_busy in reset");
		check_flag(io_valid, 1'b0, "io_valid in reset");
		check_flag(io_irq_valid, 1'b0, "io_irq_valid in reset");
		check_flag(sysinfo_iosr_valid, 1'b0, "sysinfo_iosr_valid in reset");
		inRESET <= 1'b1;
		probe_startup();
		scratch_readback();
		misaligned_drop();
		single_irqs();
		irq_priority();
		stalled_return();
		check_flag(sysinfo_iosr_valid, 1'b1, "sysinfo_iosr_valid at end");
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: io_subsystem.f
hdl/pic_pkg.sv
hdl/pic_request_buffer.sv
hdl/pic_irq_control.sv
hdl/pic_gci_size_probe.sv
hdl/peripheral_interface_controller.sv
hdl/dps_register_block.sv
hdl/gci_register_block.sv
hdl/io_subsystem_top.sv
tb/tb_io_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the I/O subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f io_subsystem.f --top-module tb_io_subsystem

./obj_dir/Vtb_io_subsystem 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
